/* Bender.yml */
package:
  name: de0_qbus

sources:
  - design/qbus_pkg.sv
  - design/qbus_panel_master.sv
  - design/qbus_ram.sv
  - design/qbus_display.sv
  - design/de0.sv
  - target: test
    files:
      - bench/tb_de0.sv

/* bench/tb_de0.sv */
/*
 * DE0 Q-bus subsystem testbench
 * Works the panel buttons and switches, keeps a model of the RAM
 * and the display register, and checks LEDs and digits
 */
`timescale 1ns/1ps
`default_nettype none

module tb_de0;
   import qbus_pkg::*;

   logic        clk;
   logic        arst_n;
   logic [2:0]  button;                              // Active low
   logic [9:0]  sw;
   seg_t        hex0;
   seg_t        hex1;
   seg_t        hex2;
   seg_t        hex3;
   wire  [9:0]  led;
   logic [15:0] ram_model [RAM_WORDS];               // Expected RAM words
   logic [15:0] disp_model;                          // Expected display value
   integer      seed;

   de0 u_dut (
      .de0_clock_50 (clk),
      .arst_n       (arst_n),
      .de0_button   (button),
      .de0_sw       (sw),
      .de0_hex0     (hex0),
      .de0_hex1     (hex1),
      .de0_hex2     (hex2),
      .de0_hex3     (hex3),
      .de0_led      (led)
   );

   always #10 clk = ~clk;                            // 20 ns period

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         fail_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_seg(input string name, input seg_t got, input seg_t exp);
      if (got !== exp)
         fail_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
   endtask

   // Segments g..a that light for each digit
   function automatic seg_t glyph_of(input logic [3:0] nib);
      logic [6:0] lit;
      case (nib)
         4'h0: lit = 7'h3F;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5B;
         4'h3: lit = 7'h4F;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6D;
         4'h6: lit = 7'h7D;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7F;
         4'h9: lit = 7'h6F;
         4'hA: lit = 7'h77;
         4'hB: lit = 7'h7C;                          // b
         4'hC: lit = 7'h39;
         4'hD: lit = 7'h5E;                          // d
         4'hE: lit = 7'h79;
         default: lit = 7'h71;                       // F
      endcase
      return {1'b1, ~lit};                           // Active low, point dark
   endfunction

   // Word write fills both lanes and a byte write only one
   function automatic logic [15:0] merge_write(input logic [15:0] old, input logic odd,
                                               input logic [7:0] d, input logic word);
      if (word)
         return {d, d};
      return odd ? {d, old[7:0]} : {old[15:8], d};
   endfunction

   function automatic logic [7:0] expect_byte(input logic [7:0] a);
      logic [15:0] w;
      w = a[7] ? disp_model : ram_model[a[6:1]];
      return a[0] ? w[15:8] : w[7:0];
   endfunction

   // Hold a button 3 cycles, then wait for the panel to go idle
   task automatic press_button(input int idx);
      bit seen;
      int n;
      seen = 0;
      n = 0;
      button[idx] = 1'b0;
      repeat (3) begin
         @(negedge clk);
         seen |= led[8];
      end
      button[idx] = 1'b1;
      while (led[8] !== 1'b0) begin
         @(negedge clk);
         n++;
         if (n == 100)
            fail_run("timeout: busy stayed high for 100 cycles after a press");
      end
      if (!seen)
         fail_run("busy never rose after a button press");
   endtask

   task automatic set_address(input logic [7:0] a);
      sw = {2'b00, a};
      press_button(0);
   endtask

   task automatic bus_write(input logic [7:0] a, input logic [7:0] d, input logic word);
      set_address(a);
      sw = {word, 1'b0, d};                          // sw[9] high for a word
      press_button(1);
      if (!a[7])
         ram_model[a[6:1]] = merge_write(ram_model[a[6:1]], a[0], d, word);
      else if (a[7:1] == DISP_ADDR[7:1])
         disp_model = merge_write(disp_model, a[0], d, word);
   endtask

   task automatic read_check(input logic [7:0] a);
      set_address(a);
      press_button(2);
      check_byte("led[7:0]", led[7:0], expect_byte(a));
      check_bit("led[9]", led[9], 1'b0);
   endtask

   task automatic check_digits;
      check_seg("hex0", hex0, glyph_of(disp_model[3:0]));
      check_seg("hex1", hex1, glyph_of(disp_model[7:4]));
      check_seg("hex2", hex2, glyph_of(disp_model[11:8]));
      check_seg("hex3", hex3, glyph_of(disp_model[15:12]));
   endtask

   task automatic check_reset_state;
      check_byte("led[7:0]", led[7:0], 8'h00);
      check_bit("led[8]", led[8], 1'b0);
      check_bit("led[9]", led[9], 1'b0);
      check_digits();                                // All zero glyphs
   endtask

   task automatic word_write_read;
      logic [5:0] idx [6];
      for (int i = 0; i < 6; i++) begin
         idx[i] = 6'($random(seed));
         bus_write({1'b0, idx[i], 1'b0}, 8'($random(seed)), 1'b1);
      end
      for (int i = 0; i < 6; i++) begin
         read_check({1'b0, idx[i], 1'b0});
         read_check({1'b0, idx[i], 1'b1});
      end
   endtask

   task automatic byte_lane_write;
      logic [5:0] idx;
      idx = 6'($random(seed));
      bus_write({1'b0, idx, 1'b0}, 8'($random(seed)), 1'b1);     // Known start
      bus_write({1'b0, idx, 1'b0}, 8'($random(seed)), 1'b0);     // Low lane
      read_check({1'b0, idx, 1'b0});
      read_check({1'b0, idx, 1'b1});
      bus_write({1'b0, idx, 1'b1}, 8'($random(seed)), 1'b0);     // High lane
      read_check({1'b0, idx, 1'b1});
      read_check({1'b0, idx, 1'b0});
   endtask

   task automatic display_access;
      bus_write(DISP_ADDR, 8'h3C, 1'b1);
      check_digits();
      read_check(DISP_ADDR);
      read_check(DISP_ADDR | 8'h01);
      bus_write(DISP_ADDR, 8'($random(seed)), 1'b0);
      check_digits();
      bus_write(DISP_ADDR | 8'h01, 8'($random(seed)), 1'b0);
      check_digits();
      read_check(DISP_ADDR);
      read_check(DISP_ADDR | 8'h01);
   endtask

   task automatic unmapped_access;
      bus_write(8'h22, 8'h5A, 1'b1);                 // Known RAM word for later
      set_address(8'h90);
      press_button(2);                               // Nobody replies
      check_bit("led[9]", led[9], 1'b1);
      bus_write(8'h90, 8'hA5, 1'b1);
      check_bit("led[9]", led[9], 1'b1);
      read_check(8'h23);                             // Read cycle clears error
   endtask

   initial begin
      clk        = 1'b0;
      arst_n     = 1'b0;
      button     = 3'b111;
      sw         = '0;
      disp_model = '0;
      seed       = 32'h0fd8_98c6;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_reset_state();
      word_write_read();
      byte_lane_write();
      display_access();
      unmapped_access();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
design/qbus_pkg.sv
design/qbus_panel_master.sv
design/qbus_ram.sv
design/qbus_display.sv
design/de0.sv
bench/tb_de0.sv

/* design/de0.sv */
/*
 * DE0 board top
 * Panel master on the buttons and switches, RAM and display slaves
 * on a shared Q-bus. Replies are wired-AND, read data is ORed
 */
`timescale 1ns/1ps
`default_nettype none

module de0 (
   input  wire             de0_clock_50,             // 50 MHz board clock
   input  wire             arst_n,                   // Async reset, active low
   input  wire  [2:0]      de0_button,               // Push buttons, active low
   input  wire  [9:0]      de0_sw,                   // Toggle switches
   output qbus_pkg::seg_t  de0_hex0,                 // Seven-segment digit 0
   output qbus_pkg::seg_t  de0_hex1,                 // Seven-segment digit 1
   output qbus_pkg::seg_t  de0_hex2,                 // Seven-segment digit 2
   output qbus_pkg::seg_t  de0_hex3,                 // Seven-segment digit 3
   output wire  [9:0]      de0_led                   // Green LEDs
);
   import qbus_pkg::*;

   wire              clk50;
   wire [DATA_W-1:0] ad_n;                           // Inverted address/data
   wire              sync_n;
   wire              din_n;
   wire              dout_n;
   wire              wtbt_n;
   wire              rply_n;                         // Combined reply
   wire [DATA_W-1:0] rdata;                          // Combined read data
   wire              ram_rply_n;
   wire [DATA_W-1:0] ram_rdata;
   wire              disp_rply_n;
   wire [DATA_W-1:0] disp_rdata;

   assign clk50  = de0_clock_50;
   assign rply_n = ram_rply_n & disp_rply_n;         // Any slave may pull low
   assign rdata  = ram_rdata | disp_rdata;           // Idle slaves drive zero

   qbus_panel_master panel (
      .clk50   (clk50),
      .arst_n  (arst_n),
      .button  (de0_button),
      .sw      (de0_sw),
      .rply_n  (rply_n),
      .rdata   (rdata),
      .ad_n    (ad_n),
      .sync_n  (sync_n),
      .din_n   (din_n),
      .dout_n  (dout_n),
      .wtbt_n  (wtbt_n),
      .led     (de0_led)
   );

   qbus_ram ram (
      .clk50   (clk50),
      .arst_n  (arst_n),
      .ad_n    (ad_n),
      .sync_n  (sync_n),
      .din_n   (din_n),
      .dout_n  (dout_n),
      .wtbt_n  (wtbt_n),
      .rply_n  (ram_rply_n),
      .rdata   (ram_rdata)
   );

   qbus_display display (
      .clk50   (clk50),
      .arst_n  (arst_n),
      .ad_n    (ad_n),
      .sync_n  (sync_n),
      .din_n   (din_n),
      .dout_n  (dout_n),
      .wtbt_n  (wtbt_n),
      .rply_n  (disp_rply_n),
      .rdata   (disp_rdata),
      .hex0    (de0_hex0),
      .hex1    (de0_hex1),
      .hex2    (de0_hex2),
      .hex3    (de0_hex3)
   );

endmodule

`default_nettype wire

/* design/qbus_display.sv */
/*
 * Q-bus display register slave
 * One 16-bit register at DISP_ADDR, written by word or byte and
 * read back as a word. Each nibble drives one seven-segment digit
 */
`timescale 1ns/1ps
`default_nettype none

module qbus_display (
   input  wire                         clk50,        // 50 MHz system clock
   input  wire                         arst_n,       // Async reset, active low
   input  wire  [qbus_pkg::DATA_W-1:0] ad_n,         // Inverted address/data
   input  wire                         sync_n,       // Address strobe
   input  wire                         din_n,        // Read strobe
   input  wire                         dout_n,       // Write strobe
   input  wire                         wtbt_n,       // Byte write in data phase
   output logic                        rply_n,       // Reply to master
   output logic [qbus_pkg::DATA_W-1:0] rdata,        // Read data, zero when idle
   output qbus_pkg::seg_t              hex0,         // Digit 0, low nibble
   output qbus_pkg::seg_t              hex1,         // Digit 1
   output qbus_pkg::seg_t              hex2,         // Digit 2
   output qbus_pkg::seg_t              hex3          // Digit 3, high nibble
);
   import qbus_pkg::*;

   qbus_word_u        bus_word;                      // True-polarity bus word
   logic              sync_q;                        // SYNC one cycle ago
   logic              sel;                           // Addressed in this cycle
   logic              lane;                          // Latched byte bit
   logic              wr_en;
   logic [DATA_W-1:0] disp_reg;                      // Value on the digits

   // Hex glyphs, active low with the decimal point dark
   function automatic seg_t hex_glyph(input logic [3:0] nib);
      case (nib)
         4'h0: hex_glyph = 8'hC0;
         4'h1: hex_glyph = 8'hF9;
         4'h2: hex_glyph = 8'hA4;
         4'h3: hex_glyph = 8'hB0;
         4'h4: hex_glyph = 8'h99;
         4'h5: hex_glyph = 8'h92;
         4'h6: hex_glyph = 8'h82;
         4'h7: hex_glyph = 8'hF8;
         4'h8: hex_glyph = 8'h80;
         4'h9: hex_glyph = 8'h90;
         4'hA: hex_glyph = 8'h88;
         4'hB: hex_glyph = 8'h83;                    // Lower case b
         4'hC: hex_glyph = 8'hC6;
         4'hD: hex_glyph = 8'hA1;                    // Lower case d
         4'hE: hex_glyph = 8'h86;
         default: hex_glyph = 8'h8E;                 // F
      endcase
   endfunction

   assign bus_word.data = ~ad_n;

   // Select latched on SYNC falling edge, byte bit ignored for the match
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= 1'b1;
         sel    <= 1'b0;
         lane   <= 1'b0;
      end else begin
         sync_q <= sync_n;
         if (sync_q && !sync_n) begin
            sel  <= ({bus_word.addr.io, bus_word.addr.index} == DISP_ADDR[ADDR_W-1:1]);
            lane <= bus_word.addr.byte_bit;
         end else if (sync_n) begin
            sel <= 1'b0;
         end
      end
   end

   assign wr_en = sel && !dout_n && rply_n;

   // Register, reply and read data
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         disp_reg <= '0;                             // Digits show 0000
         rply_n   <= 1'b1;
         rdata    <= '0;
      end else if (wr_en) begin
         if (wtbt_n || !lane)
            disp_reg[7:0]  <= bus_word.data[7:0];
         if (wtbt_n || lane)
            disp_reg[15:8] <= bus_word.data[15:8];
         rply_n <= 1'b0;
      end else if (sel && !din_n && rply_n) begin
         rply_n <= 1'b0;
         rdata  <= disp_reg;
      end else if (din_n && dout_n) begin
         rply_n <= 1'b1;                             // Strobe gone, release
         rdata  <= '0;
      end
   end

   assign hex0 = hex_glyph(disp_reg[3:0]);
   assign hex1 = hex_glyph(disp_reg[7:4]);
   assign hex2 = hex_glyph(disp_reg[11:8]);
   assign hex3 = hex_glyph(disp_reg[15:12]);

endmodule

`default_nettype wire

/* design/qbus_panel_master.sv */
/*
 * Front-panel bus master
 * Synchronizes the push buttons and turns presses into Q-bus cycles:
 * button 0 latches the address, button 1 writes a byte or word,
 * button 2 reads a word. A missing RPLY ends the cycle with an error
 */
`timescale 1ns/1ps
`default_nettype none

module qbus_panel_master (
   input  wire                         clk50,        // 50 MHz system clock
   input  wire                         arst_n,       // Async reset, active low
   input  wire  [2:0]                  button,       // Push buttons, active low
   input  wire  [9:0]                  sw,           // Toggle switches
   input  wire                         rply_n,       // Combined slave reply
   input  wire  [qbus_pkg::DATA_W-1:0] rdata,        // Combined read data
   output logic [qbus_pkg::DATA_W-1:0] ad_n,         // Inverted address/data
   output logic                        sync_n,       // Address strobe
   output logic                        din_n,        // Read strobe
   output logic                        dout_n,       // Write strobe
   output logic                        wtbt_n,       // Write/byte status
   output logic [9:0]                  led           // Error, busy, read byte
);
   import qbus_pkg::*;

   logic [2:0]        btn_s1;                        // First sync stage
   logic [2:0]        btn_s2;                        // Second sync stage
   logic [2:0]        btn_s3;                        // Previous synced level
   logic [2:0]        press;                         // One-cycle press pulses
   logic [2:0]        state;
   logic [ADDR_W-1:0] addr;                          // Latched byte address
   logic              is_wr;                         // Current cycle is a write
   logic              byte_wr;                       // Byte write, from sw[9]
   logic [DATA_W-1:0] wr_word;                       // Write data, lanes placed
   logic [DATA_W-1:0] rd_word;                       // Last word read
   logic [TMO_W-1:0]  tmo_cnt;                       // Reply wait counter
   logic              error;                         // Reply timeout seen
   logic              busy;
   logic              start;                         // Bus cycle starts

   // Two-flop synchronizer plus edge history
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         btn_s1 <= '1;                               // Buttons idle high
         btn_s2 <= '1;
         btn_s3 <= '1;
      end else begin
         btn_s1 <= button;
         btn_s2 <= btn_s1;
         btn_s3 <= btn_s2;
      end
   end

   assign press = btn_s3 & ~btn_s2;                  // Falling edge = press
   assign busy  = (state != ST_IDLE);
   assign start = (state == ST_IDLE) && !press[0] && (press[1] || press[2]);

   // Write data is placed on its lanes when the cycle starts
   always_ff @(posedge clk50) begin
      if (start) begin
         byte_wr <= ~sw[9];
         if (sw[9])
            wr_word <= {sw[7:0], sw[7:0]};           // Word, byte in both lanes
         else if (addr[0])
            wr_word <= {sw[7:0], 8'h00};             // Odd byte lane
         else
            wr_word <= {8'h00, sw[7:0]};             // Even byte lane
      end
   end

   // Bus cycle sequencer
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         state   <= ST_IDLE;
         ad_n    <= '1;                              // Released bus reads as ones
         sync_n  <= 1'b1;
         din_n   <= 1'b1;
         dout_n  <= 1'b1;
         wtbt_n  <= 1'b1;
         addr    <= '0;
         is_wr   <= 1'b0;
         rd_word <= '0;
         tmo_cnt <= '0;
         error   <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (press[0]) begin
                  addr  <= sw[ADDR_W-1:0];           // No bus cycle, one busy cycle
                  state <= ST_FIN;
               end else if (start) begin
                  error  <= 1'b0;                    // Cleared by the new cycle
                  is_wr  <= press[1];
                  ad_n   <= ~{{(DATA_W-ADDR_W){1'b0}}, addr};
                  sync_n <= 1'b0;
                  wtbt_n <= ~press[1];               // Low in address phase on write
                  state  <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               tmo_cnt <= '0;
               if (is_wr) begin
                  ad_n   <= ~wr_word;
                  dout_n <= 1'b0;
                  wtbt_n <= ~byte_wr;                // Low in data phase on byte write
               end else begin
                  ad_n   <= '1;                      // Bus free for the slave
                  din_n  <= 1'b0;
                  wtbt_n <= 1'b1;
               end
               state <= ST_STRB;
            end
            ST_STRB: begin
               tmo_cnt <= tmo_cnt + 1'b1;            // Slave sees strobe here
               state   <= ST_WAIT;
            end
            ST_WAIT: begin
               if (!rply_n) begin
                  state <= ST_FIN;
               end else if (tmo_cnt == TMO_W'(REPLY_TIMEOUT - 1)) begin
                  error <= 1'b1;                     // Nobody answered
                  state <= ST_FIN;
               end else begin
                  tmo_cnt <= tmo_cnt + 1'b1;
               end
            end
            ST_FIN: begin
               if (!din_n && !rply_n)
                  rd_word <= rdata;                  // Slave holds data until DIN rises
               ad_n   <= '1;
               sync_n <= 1'b1;
               din_n  <= 1'b1;
               dout_n <= 1'b1;
               wtbt_n <= 1'b1;
               state  <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign led[7:0] = addr[0] ? rd_word[15:8] : rd_word[7:0];   // Byte at address
   assign led[8]   = busy;
   assign led[9]   = error;

endmodule

`default_nettype wire

/* design/qbus_pkg.sv */
/*
 * Q-bus panel subsystem definitions
 * Bus widths, address map, reply timeout, panel FSM state codes,
 * seven-segment pattern type and the two-view bus word
 */
`default_nettype none

package qbus_pkg;

   localparam int DATA_W        = 16;                  // Bus word width
   localparam int ADDR_W        = 8;                   // Byte address from the switches
   localparam int RAM_WORDS     = 64;                  // RAM depth in words
   localparam int RAM_IDX_W     = $clog2(RAM_WORDS);   // Word index width
   localparam int REPLY_TIMEOUT = 16;                  // Cycles to wait for RPLY
   localparam int TMO_W         = $clog2(REPLY_TIMEOUT);

   // Display register, word access to 0x80 or 0x81
   localparam logic [ADDR_W-1:0] DISP_ADDR = 8'h80;

   localparam logic [2:0] ST_IDLE = 3'd0;              // Waiting for a press
   localparam logic [2:0] ST_ADDR = 3'd1;              // SYNC low, address on bus
   localparam logic [2:0] ST_STRB = 3'd2;              // DIN or DOUT just asserted
   localparam logic [2:0] ST_WAIT = 3'd3;              // Waiting for RPLY
   localparam logic [2:0] ST_FIN  = 3'd4;              // Capture and release

   // Active low, bits 6..0 are g..a, bit 7 is the decimal point
   typedef logic [7:0] seg_t;

   // One bus word, read as an address or as data
   typedef union packed {
      struct packed {
         logic [DATA_W-ADDR_W-1:0] unused;             // Upper byte, zero from panel
         logic                     io;                 // I/O page bit
         logic [RAM_IDX_W-1:0]     index;              // Word index
         logic                     byte_bit;           // Odd byte select
      } addr;
      logic [DATA_W-1:0] data;                         // Plain data word
   } qbus_word_u;

endpackage

`default_nettype wire

/* design/qbus_ram.sv */
/*
 * Q-bus RAM slave
 * 64 words, answers any address with the I/O bit clear.
 * Word writes, byte-lane writes under WTBT, word reads
 */
`timescale 1ns/1ps
`default_nettype none

module qbus_ram (
   input  wire                         clk50,        // 50 MHz system clock
   input  wire                         arst_n,       // Async reset, active low
   input  wire  [qbus_pkg::DATA_W-1:0] ad_n,         // Inverted address/data
   input  wire                         sync_n,       // Address strobe
   input  wire                         din_n,        // Read strobe
   input  wire                         dout_n,       // Write strobe
   input  wire                         wtbt_n,       // Byte write in data phase
   output logic                        rply_n,       // Reply to master
   output logic [qbus_pkg::DATA_W-1:0] rdata         // Read data, zero when idle
);
   import qbus_pkg::*;

   qbus_word_u           bus_word;                   // True-polarity bus word
   logic [DATA_W-1:0]    mem [RAM_WORDS];
   logic                 sync_q;                     // SYNC one cycle ago
   logic                 sel;                        // Addressed in this cycle
   logic [RAM_IDX_W-1:0] index;                      // Latched word index
   logic                 lane;                       // Latched byte bit
   logic                 wr_en;

   assign bus_word.data = ~ad_n;

   // Address decode on the falling edge of SYNC
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= 1'b1;
         sel    <= 1'b0;
         index  <= '0;
         lane   <= 1'b0;
      end else begin
         sync_q <= sync_n;
         if (sync_q && !sync_n) begin
            sel   <= ~bus_word.addr.io;              // Low half of the map
            index <= bus_word.addr.index;
            lane  <= bus_word.addr.byte_bit;
         end else if (sync_n) begin
            sel <= 1'b0;                             // Cycle over
         end
      end
   end

   assign wr_en = sel && !dout_n && rply_n;          // Once per DOUT

   always_ff @(posedge clk50) begin
      if (wr_en) begin
         if (wtbt_n || !lane)
            mem[index][7:0]  <= bus_word.data[7:0];
         if (wtbt_n || lane)
            mem[index][15:8] <= bus_word.data[15:8];
      end
   end

   // Reply one cycle after the strobe, drop it when the strobe goes high
   always_ff @(posedge clk50 or negedge arst_n) begin
      if (!arst_n) begin
         rply_n <= 1'b1;
         rdata  <= '0;
      end else if (sel && !din_n && rply_n) begin
         rply_n <= 1'b0;
         rdata  <= mem[index];                       // Data valid with RPLY
      end else if (wr_en) begin
         rply_n <= 1'b0;
      end else if (din_n && dout_n) begin
         rply_n <= 1'b1;
         rdata  <= '0;
      end
   end

endmodule

`default_nettype wire
